//--- Bender.yml
package:
  name: edge_pe

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/edge_pe_pkg.sv
      - verilog/task_decode.sv
      - verilog/neighbor_fetch.sv
      - verilog/aggr_result.sv
      - verilog/edge_pe.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/edge_pe_checker.sv
      - verif/edge_pe_tb.sv

//--- compile.f
+incdir+verilog
verilog/edge_pe_pkg.sv
verilog/task_decode.sv
verilog/neighbor_fetch.sv
verilog/aggr_result.sv
verilog/edge_pe.sv
verif/edge_pe_checker.sv
verif/edge_pe_tb.sv

//--- verif/edge_pe_checker.sv
`timescale 1ns/1ns

module edge_pe_checker (
    input logic                      clk,
    input logic                      reset,
    input logic                      idle,
    input edge_pe_pkg::arb_req_t     arb_req,
    input logic                      grant,
    input logic                      req_wb_packet,
    input logic                      grant_wb,
    input edge_pe_pkg::task_packet_t imem_out
);
    int fail_count = 0;   // count of failed assertions

    // fields frozen until the arbiter grants
    req_stable: assert property (@(posedge clk) disable iff (reset)
        arb_req.req && !grant |=> arb_req.req && $stable(arb_req))
        else begin
            $error("arbiter request dropped or changed before grant");
            fail_count++;
        end

    idle_no_req: assert property (@(posedge clk) disable iff (reset)
        idle |-> !arb_req.req)
        else begin
            $error("arbiter request raised while idle");
            fail_count++;
        end

    // packet valid and held until the write-back grant
    wb_has_packet: assert property (@(posedge clk) disable iff (reset)
        req_wb_packet && !grant_wb |=> req_wb_packet && imem_out.valid && $stable(imem_out))
        else begin
            $error("write-back request without a valid, stable task packet");
            fail_count++;
        end

endmodule

bind edge_pe edge_pe_checker u_check (
    .clk           (clk),
    .reset         (reset),
    .idle          (idle),
    .arb_req       (arb_req),
    .grant         (grant),
    .req_wb_packet (req_wb_packet),
    .grant_wb      (grant_wb),
    .imem_out      (imem_out)
);

//--- verif/edge_pe_tb.sv
`timescale 1ns/1ns
`include "edge_pe_config.svh"

module edge_pe_tb;
    import edge_pe_pkg::*;

    localparam int NUM_TESTS  = 200;
    localparam int MAX_CYCLES = NUM_TESTS * 9 * 24;   // up to 9 requests of 24 cycles

    logic           clk;
    logic           reset;
    dispatch_task_t task_in;
    logic           idle;
    arb_req_t       arb_req;
    logic           grant;
    id_beat_t       id_in;
    fv_beat_t       fv_in;
    bank_beat_t     bank_out;
    logic           req_wb_packet;
    logic           grant_wb;
    task_packet_t   imem_out;
    replay_iter_t   cur_replay_iter;

    node_id_t cur_target;
    logic     cur_more;
    node_id_t nbr [`MAX_DEGREE];
    int       errors;
    int       cycles;
    int       done_seen;
    int       total;
    logic     running;
    logic     wb_pending;
    fv_beat_t drv_beat;    // beat on fv_in this cycle
    logic     drv_valid;
    logic     drv_last;
    fv_beat_t held_beat;   // beat from the cycle before
    logic     held_valid;
    logic     held_last;

    edge_pe #(.PE_TAG(2'd1)) uut (
        .clk             (clk),
        .reset           (reset),
        .task_in         (task_in),
        .idle            (idle),
        .arb_req         (arb_req),
        .grant           (grant),
        .id_in           (id_in),
        .fv_in           (fv_in),
        .bank_out        (bank_out),
        .req_wb_packet   (req_wb_packet),
        .grant_wb        (grant_wb),
        .imem_out        (imem_out),
        .cur_replay_iter (cur_replay_iter)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: no finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic fail_check(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic check_arb(input arb_req_t got, input arb_req_t exp);
        if (got !== exp) begin
            fail_check($sformatf("arbiter request %h, expected %h", got, exp));
        end
    endtask

    task automatic check_bank(input bank_beat_t got, input bank_beat_t exp);
        if (got !== exp) begin
            fail_check($sformatf("bank beat %h, expected %h", got, exp));
        end
    endtask

    task automatic check_packet(input task_packet_t got, input task_packet_t exp);
        if (got !== exp) begin
            fail_check($sformatf("task packet %h, expected %h", got, exp));
        end
    endtask

    // bank output lags fv_in by one cycle
    always @(negedge clk) begin : bank_monitor
        bank_beat_t exp;
        if (running) begin
            exp.sos       = held_valid && held_beat.sos;
            exp.eos       = held_valid && held_beat.eos;
            exp.done_aggr = held_valid && held_last && !cur_more;
            if (held_valid && held_last && cur_more) begin
                wb_pending = 1'b1;
            end
            exp.wb_en   = wb_pending;
            exp.node_id = (held_valid || wb_pending) ? cur_target : bank_out.node_id;
            exp.fv      = held_valid ? held_beat.fv : bank_out.fv;
            check_bank(bank_out, exp);
            if (req_wb_packet !== wb_pending) begin
                fail_check($sformatf("write-back request %b, expected %b", req_wb_packet,
                                     wb_pending));
            end
            if (bank_out.done_aggr) begin
                done_seen++;
            end
            if (wb_pending && grant_wb) begin
                wb_pending = 1'b0;   // granted at the next edge
            end
        end
        held_beat  = drv_beat;
        held_valid = drv_valid;
        held_last  = drv_last;
    end

    task automatic grant_request(input arb_req_t exp);
        int delay;
        delay = $urandom_range(0, 5);
        @(negedge clk);
        while (!arb_req.req) begin
            @(negedge clk);
        end
        check_arb(arb_req, exp);
        repeat (delay) begin
            @(negedge clk);
            check_arb(arb_req, exp);
        end
        @(posedge clk);
        grant <= 1'b1;
        @(negedge clk);
        check_arb(arb_req, exp);
        @(posedge clk);
        grant <= 1'b0;
    endtask

    task automatic stream_ids(input int deg);
        id_beat_t beat;
        int       nbeats;
        nbeats = (deg + 1) / 2;
        repeat ($urandom_range(0, 4)) @(posedge clk);
        for (int b = 0; b < nbeats; b++) begin
            beat              = '0;
            beat.sos          = (b == 0);
            beat.eos          = (b == nbeats - 1);
            beat.neighbor_num = (b == 0) ? deg_cnt_t'(deg) : '0;
            for (int i = 0; i < 2; i++) begin
                beat.ids[i] = (2 * b + i < deg) ? nbr[2 * b + i] : node_id_t'($urandom);
            end
            id_in <= beat;
            @(posedge clk);
        end
        id_in <= '0;
    endtask

    task automatic stream_features(input bit last_nbr);
        fv_beat_t beat;
        int       nbeats;
        nbeats = $urandom_range(1, 4);
        repeat ($urandom_range(0, 4)) @(posedge clk);
        for (int b = 0; b < nbeats; b++) begin
            beat.sos   = (b == 0);
            beat.eos   = (b == nbeats - 1);
            beat.fv[0] = fv_t'($urandom);
            beat.fv[1] = fv_t'($urandom);
            fv_in     <= beat;
            drv_beat   = beat;
            drv_valid  = 1'b1;
            drv_last   = last_nbr && beat.eos;
            @(posedge clk);
        end
        fv_in    <= '0;
        drv_valid = 1'b0;
        drv_last  = 1'b0;
    endtask

    task automatic grant_write_back(input task_packet_t exp);
        int delay;
        delay = $urandom_range(0, 5);
        @(negedge clk);
        if (!req_wb_packet) begin
            errors++;
            $display("write-back request missing after the last stream at %0t ns", $time);
        end
        check_packet(imem_out, exp);
        repeat (delay) begin
            @(negedge clk);
            check_packet(imem_out, exp);
        end
        @(posedge clk);
        grant_wb <= 1'b1;
        @(negedge clk);
        check_packet(imem_out, exp);
        @(posedge clk);
        grant_wb <= 1'b0;
    endtask

    task automatic run_test(input int t);
        dispatch_task_t tsk;
        arb_req_t       exp_req;
        task_packet_t   exp_pkt;
        replay_iter_t   iter;
        int             deg;
        int             errs_before;
        errs_before   = errors;
        deg           = $urandom_range(1, `MAX_DEGREE);
        tsk.valid     = 1'b1;
        tsk.iter_mask = iter_mask_t'($urandom);
        tsk.prio      = prio_t'($urandom);
        tsk.target    = node_id_t'($urandom);
        iter          = replay_iter_t'($urandom);
        for (int i = 0; i < deg; i++) begin
            nbr[i] = node_id_t'($urandom);
        end
        @(negedge clk);
        while (!idle) begin
            @(negedge clk);
        end
        @(posedge clk);
        cur_target = tsk.target;
        cur_more   = (tsk.iter_mask >> (int'(iter) + 1)) != 0;   // replay left
        done_seen  = 0;
        running    = 1'b1;
        task_in         <= tsk;
        cur_replay_iter <= iter;
        @(posedge clk);
        task_in <= '0;
        exp_req = '{req: 1'b1, pe_tag: 2'd1, kind: KIND_NBR_ID, node_id: tsk.target};
        grant_request(exp_req);
        stream_ids(deg);
        for (int k = 0; k < deg; k++) begin
            exp_req.kind    = KIND_FEATURE;
            exp_req.node_id = nbr[k];
            grant_request(exp_req);
            stream_features(k == deg - 1);
        end
        if (cur_more) begin
            exp_pkt = '{valid: 1'b1, iter_mask: tsk.iter_mask, prio: tsk.prio,
                        target: tsk.target};
            grant_write_back(exp_pkt);
        end
        @(negedge clk);
        while (!idle) begin
            @(negedge clk);
        end
        @(posedge clk);
        if (done_seen != (cur_more ? 0 : 1)) begin
            errors++;
            $display("test %0d saw %0d done beats on the bank output", t, done_seen);
        end
        $display("test %0d: target %0d, %0d neighbors, %s, %s", t, tsk.target, deg,
                 cur_more ? "write-back" : "done", (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        void'($urandom(32'h9bb36fbd));
        errors          = 0;
        cycles          = 0;
        done_seen       = 0;
        running         = 1'b0;
        wb_pending      = 1'b0;
        drv_beat        = '0;
        drv_valid       = 1'b0;
        drv_last        = 1'b0;
        reset           = 1'b1;
        task_in         = '0;
        grant           = 1'b0;
        id_in           = '0;
        fv_in           = '0;
        grant_wb        = 1'b0;
        cur_replay_iter = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (idle !== 1'b1 || arb_req.req !== 1'b0 || req_wb_packet !== 1'b0
                || imem_out.valid !== 1'b0 || bank_out.sos !== 1'b0
                || bank_out.eos !== 1'b0 || bank_out.done_aggr !== 1'b0
                || bank_out.wb_en !== 1'b0) begin
            fail_check("outputs not at their reset values");
        end
        $display("reset state: %s", (errors == 0) ? "ok" : "mismatch");
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        total = errors + uut.u_check.fail_count;
        $display("%0d tests, %0d errors, %0d cycles", NUM_TESTS, total, cycles);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verilog/aggr_result.sv
`timescale 1ns/1ns

module aggr_result (
    input  logic                      clk,
    input  logic                      reset,
    input  edge_pe_pkg::task_info_t   info,
    input  edge_pe_pkg::fv_beat_t     fwd,
    input  logic                      fwd_valid,
    input  logic                      fetch_done,
    input  logic                      grant_wb,
    output edge_pe_pkg::bank_beat_t   bank_out,
    output logic                      req_wb_packet,
    output edge_pe_pkg::task_packet_t imem_out,
    output logic                      task_done
);
    import edge_pe_pkg::*;

    result_state_t state;
    logic          done_now;
    logic          wb_active;

    // completion begins together with the last forwarded beat
    assign done_now  = fetch_done && !info.more_iters;
    assign wb_active = (state == RES_WB) || (fetch_done && info.more_iters);

    assign req_wb_packet = wb_active;
    assign task_done     = done_now || (wb_active && grant_wb);

    always_comb begin
        bank_out.sos       = fwd_valid && fwd.sos;
        bank_out.eos       = fwd_valid && fwd.eos;
        bank_out.done_aggr = done_now;
        bank_out.wb_en     = wb_active;   // bank drains its result
        bank_out.node_id   = info.target;
        bank_out.fv        = fwd.fv;
    end

    // same task again for the next replay pass
    always_comb begin
        imem_out.valid     = wb_active;
        imem_out.iter_mask = info.iter_mask;
        imem_out.prio      = info.prio;
        imem_out.target    = info.target;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RES_FWD;
        end else begin
            case (state)
                RES_FWD: begin
                    if (fetch_done && info.more_iters && !grant_wb) begin
                        state <= RES_WB;
                    end
                end
                RES_WB: begin
                    if (grant_wb) begin
                        state <= RES_FWD;
                    end
                end
                default: state <= RES_FWD;
            endcase
        end
    end

endmodule

//--- verilog/edge_pe.sv
`timescale 1ns/1ns

module edge_pe #(
    parameter logic [1:0] PE_TAG = 2'd0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  edge_pe_pkg::dispatch_task_t task_in,
    output logic                      idle,
    output edge_pe_pkg::arb_req_t     arb_req,
    input  logic                      grant,
    input  edge_pe_pkg::id_beat_t     id_in,
    input  edge_pe_pkg::fv_beat_t     fv_in,
    output edge_pe_pkg::bank_beat_t   bank_out,
    output logic                      req_wb_packet,
    input  logic                      grant_wb,
    output edge_pe_pkg::task_packet_t imem_out,
    input  edge_pe_pkg::replay_iter_t cur_replay_iter
);
    import edge_pe_pkg::*;

    task_info_t info;
    fv_beat_t   fwd;
    logic       task_start;
    logic       task_done;
    logic       fwd_valid;
    logic       fetch_done;

    task_decode u_decode (
        .clk             (clk),
        .reset           (reset),
        .task_in         (task_in),
        .cur_replay_iter (cur_replay_iter),
        .task_done       (task_done),
        .idle            (idle),
        .task_start      (task_start),
        .info            (info)
    );

    // neighbor list then one feature stream per neighbor
    neighbor_fetch #(
        .PE_TAG (PE_TAG)
    ) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .task_start (task_start),
        .info       (info),
        .grant      (grant),
        .id_in      (id_in),
        .fv_in      (fv_in),
        .arb_req    (arb_req),
        .fwd        (fwd),
        .fwd_valid  (fwd_valid),
        .fetch_done (fetch_done)
    );

    aggr_result u_result (
        .clk           (clk),
        .reset         (reset),
        .info          (info),
        .fwd           (fwd),
        .fwd_valid     (fwd_valid),
        .fetch_done    (fetch_done),
        .grant_wb      (grant_wb),
        .bank_out      (bank_out),
        .req_wb_packet (req_wb_packet),
        .imem_out      (imem_out),
        .task_done     (task_done)
    );

endmodule

//--- verilog/edge_pe_config.svh
`ifndef EDGE_PE_CONFIG_SVH
`define EDGE_PE_CONFIG_SVH

// node and feature widths
`define NODE_ID_W    7
`define FV_W         8
`define FV_PER_BEAT  2
`define IDS_PER_BEAT 2

// task limits
`define MAX_DEGREE   8
`define ITER_MASK_W  4   // one bit per replay iteration
`define PRIO_W       3

`endif

//--- verilog/edge_pe_pkg.sv
`include "edge_pe_config.svh"

package edge_pe_pkg;

    typedef logic [`NODE_ID_W-1:0]            node_id_t;
    typedef logic [`FV_W-1:0]                 fv_t;
    typedef logic [$clog2(`MAX_DEGREE+1)-1:0] deg_cnt_t;     // 0 to MAX_DEGREE
    typedef logic [`ITER_MASK_W-1:0]          iter_mask_t;
    typedef logic [$clog2(`ITER_MASK_W)-1:0]  replay_iter_t;
    typedef logic [`PRIO_W-1:0]               prio_t;

    typedef enum logic {
        KIND_NBR_ID  = 1'b0,
        KIND_FEATURE = 1'b1
    } req_kind_t;

    typedef struct packed {
        logic       valid;
        iter_mask_t iter_mask;
        prio_t      prio;
        node_id_t   target;
    } dispatch_task_t;

    // re-issued task towards the IMEM controller
    typedef struct packed {
        logic       valid;
        iter_mask_t iter_mask;
        prio_t      prio;
        node_id_t   target;
    } task_packet_t;

    typedef struct packed {
        logic       req;
        logic [1:0] pe_tag;
        req_kind_t  kind;
        node_id_t   node_id;
    } arb_req_t;

    typedef struct packed {
        logic                         sos;
        logic                         eos;
        deg_cnt_t                     neighbor_num;   // valid on the sos beat
        node_id_t [`IDS_PER_BEAT-1:0] ids;
    } id_beat_t;

    typedef struct packed {
        logic                   sos;
        logic                   eos;
        fv_t [`FV_PER_BEAT-1:0] fv;
    } fv_beat_t;

    typedef struct packed {
        logic                   sos;
        logic                   eos;
        logic                   done_aggr;
        logic                   wb_en;
        node_id_t               node_id;
        fv_t [`FV_PER_BEAT-1:0] fv;
    } bank_beat_t;

    typedef struct packed {
        node_id_t   target;
        prio_t      prio;
        iter_mask_t iter_mask;
        logic       more_iters;   // replay left after this pass
    } task_info_t;

    typedef enum logic {
        DEC_IDLE,
        DEC_BUSY
    } decode_state_t;

    typedef enum logic [2:0] {
        F_IDLE,
        F_REQ_ID,
        F_WAIT_ID,
        F_STREAM_ID,
        F_REQ_FV,
        F_WAIT_FV,
        F_STREAM_FV
    } fetch_state_t;

    typedef enum logic {
        RES_FWD,
        RES_WB
    } result_state_t;

endpackage

//--- verilog/neighbor_fetch.sv
`timescale 1ns/1ns
`include "edge_pe_config.svh"

module neighbor_fetch #(
    parameter logic [1:0] PE_TAG = 2'd0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    task_start,
    input  edge_pe_pkg::task_info_t info,
    input  logic                    grant,
    input  edge_pe_pkg::id_beat_t   id_in,
    input  edge_pe_pkg::fv_beat_t   fv_in,
    output edge_pe_pkg::arb_req_t   arb_req,
    output edge_pe_pkg::fv_beat_t   fwd,
    output logic                    fwd_valid,
    output logic                    fetch_done
);
    import edge_pe_pkg::*;

    localparam int PTR_W = $clog2(`MAX_DEGREE);

    fetch_state_t     state;
    fetch_state_t     next_state;
    node_id_t         nbr_ids [`MAX_DEGREE];
    logic [PTR_W-1:0] wr_ptr;     // next free buffer slot
    logic [PTR_W-1:0] fv_ptr;     // neighbor being fetched
    deg_cnt_t         nbr_num;
    logic             id_take;
    logic             fv_take;
    logic             fv_end;
    logic             last_nbr;

    // streams carry no gaps once sos is seen
    assign id_take  = (state == F_WAIT_ID && id_in.sos) || state == F_STREAM_ID;
    assign fv_take  = (state == F_WAIT_FV && fv_in.sos) || state == F_STREAM_FV;
    assign fv_end   = fv_take && fv_in.eos;
    assign last_nbr = (deg_cnt_t'(fv_ptr) + deg_cnt_t'(1)) == nbr_num;

    always_comb begin
        next_state = state;
        case (state)
            F_IDLE: begin
                if (task_start) begin
                    next_state = F_REQ_ID;
                end
            end
            F_REQ_ID: begin
                if (grant) begin
                    next_state = F_WAIT_ID;
                end
            end
            F_WAIT_ID: begin
                if (id_in.sos) begin
                    next_state = id_in.eos ? F_REQ_FV : F_STREAM_ID;
                end
            end
            F_STREAM_ID: begin
                if (id_in.eos) begin
                    next_state = F_REQ_FV;
                end
            end
            F_REQ_FV: begin
                if (grant) begin
                    next_state = F_WAIT_FV;
                end
            end
            F_WAIT_FV, F_STREAM_FV: begin
                if (fv_end) begin
                    next_state = last_nbr ? F_IDLE : F_REQ_FV;
                end else if (fv_take) begin
                    next_state = F_STREAM_FV;
                end
            end
            default: next_state = F_IDLE;
        endcase
    end

    // request held by state until the grant cycle
    always_comb begin
        arb_req        = '0;
        arb_req.pe_tag = PE_TAG;
        if (state == F_REQ_ID) begin
            arb_req.req     = 1'b1;
            arb_req.kind    = KIND_NBR_ID;
            arb_req.node_id = info.target;
        end else if (state == F_REQ_FV) begin
            arb_req.req     = 1'b1;
            arb_req.kind    = KIND_FEATURE;
            arb_req.node_id = nbr_ids[fv_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= F_IDLE;
            wr_ptr     <= '0;
            fv_ptr     <= '0;
            fwd_valid  <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            state      <= next_state;
            fwd_valid  <= fv_take;
            fetch_done <= fv_end && last_nbr;   // lines up with the last forwarded beat
            if (task_start) begin
                wr_ptr <= '0;
                fv_ptr <= '0;
            end
            if (id_take) begin
                wr_ptr <= wr_ptr + PTR_W'(`IDS_PER_BEAT);
            end
            if (fv_end) begin
                fv_ptr <= fv_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (id_take) begin
            for (int i = 0; i < `IDS_PER_BEAT; i++) begin
                nbr_ids[wr_ptr + PTR_W'(i)] <= id_in.ids[i];
            end
        end
        if (state == F_WAIT_ID && id_in.sos) begin
            nbr_num <= id_in.neighbor_num;   // count only on first beat
        end
        if (fv_take) begin
            fwd <= fv_in;
        end
    end

endmodule

//--- verilog/task_decode.sv
`timescale 1ns/1ns
`include "edge_pe_config.svh"

module task_decode (
    input  logic                        clk,
    input  logic                        reset,
    input  edge_pe_pkg::dispatch_task_t task_in,
    input  edge_pe_pkg::replay_iter_t   cur_replay_iter,
    input  logic                        task_done,
    output logic                        idle,
    output logic                        task_start,
    output edge_pe_pkg::task_info_t     info
);
    import edge_pe_pkg::*;

    decode_state_t state;
    logic          accept;
    logic          more_iters;

    assign idle   = (state == DEC_IDLE);
    assign accept = idle && task_in.valid;

    // any mask bit above the current iteration
    always_comb begin
        more_iters = 1'b0;
        for (int i = 0; i < `ITER_MASK_W; i++) begin
            if (i > int'(cur_replay_iter) && task_in.iter_mask[i]) begin
                more_iters = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= DEC_IDLE;
            task_start <= 1'b0;
        end else begin
            task_start <= accept;   // one cycle pulse
            case (state)
                DEC_IDLE: begin
                    if (accept) begin
                        state <= DEC_BUSY;
                    end
                end
                DEC_BUSY: begin
                    if (task_done) begin
                        state <= DEC_IDLE;
                    end
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    // held for the whole task
    always_ff @(posedge clk) begin
        if (accept) begin
            info.target     <= task_in.target;
            info.prio       <= task_in.prio;
            info.iter_mask  <= task_in.iter_mask;
            info.more_iters <= more_iters;
        end
    end

endmodule
